//--- rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// Data and instruction width
`define RV_XLEN 32

// Instruction memory word address width, 256 words
`define RV_IMEM_AW 8

// Data memory word address width, 64 words
`define RV_DMEM_AW 6

`endif

//--- rv_pkg.sv
`include "rv_defs.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;    // Register and memory data

    typedef logic [4:0] reg_idx_t;          // x0 .. x31

    // R-format field layout, also used to reach I and S fields
    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } inst_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    localparam logic [6:0] OPC_OP     = 7'b0110011;  // Register-register ALU
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;  // Register-immediate ALU
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

endpackage

//--- rv_word_ram.sv
module rv_word_ram #(
    parameter int  AW        = 6,
    parameter type payload_t = rv_pkg::word_t
) (
    input  logic          CLK,
    input  logic          we,
    input  logic [AW-1:0] waddr,
    input  payload_t      wdata,
    input  logic [AW-1:0] raddr,
    output payload_t      rdata
);

    localparam int DEPTH = 2 ** AW;

    payload_t mem [DEPTH];      // Contents undefined until written

    // Write side, one word per edge
    always_ff @(posedge CLK) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Read side is combinational so fetch and load complete in-cycle
    assign rdata = mem[raddr];

endmodule

//--- rv_regfile.sv
module rv_regfile (
    input  logic             CLK,
    input  logic             RST,
    input  rv_pkg::reg_idx_t rs1,
    input  rv_pkg::reg_idx_t rs2,
    input  logic             we,
    input  rv_pkg::reg_idx_t rd,
    input  rv_pkg::word_t    wdata,
    output rv_pkg::word_t    rdata1,
    output rv_pkg::word_t    rdata2
);

    import rv_pkg::*;

    localparam int NREGS = 2 ** $bits(reg_idx_t);

    word_t regs [1:NREGS-1];    // x0 is not stored

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 1; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[rd] <= wdata;  // Decoder never asserts we for rd == 0
        end
    end

    // Asynchronous reads, x0 hardwired to zero
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- rv_decoder.sv
module rv_decoder (
    input  rv_pkg::inst_t    inst,
    output rv_pkg::reg_idx_t rs1,
    output rv_pkg::reg_idx_t rs2,
    output rv_pkg::reg_idx_t rd,
    output rv_pkg::alu_op_e  alu_op,
    output rv_pkg::word_t    imm,
    output logic             use_imm,
    output logic             reg_we,
    output logic             is_load,
    output logic             is_store
);

    import rv_pkg::*;

    word_t imm_i;
    word_t imm_s;
    logic  rd_nz;

    // Maps funct3 to an ALU operation.
    // Instruction bit 30 picks sub only for register forms and sra for both
    function automatic alu_op_e funct_to_op(
        input logic [2:0] f3,
        input logic       alt,
        input logic       is_reg
    );
        alu_op_e op;
        case (f3)
            3'b000:  op = (alt && is_reg) ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    // Register fields sit in fixed positions for every format
    assign rs1 = inst.rs1;
    assign rs2 = inst.rs2;
    assign rd  = inst.rd;

    // Sign-extended 12-bit immediates
    assign imm_i = word_t'($signed({inst.funct7, inst.rs2}));  // Bits 31:20
    assign imm_s = word_t'($signed({inst.funct7, inst.rd}));   // Bits 31:25, 11:7

    assign rd_nz = (inst.rd != '0);

    always_comb begin
        alu_op   = ALU_ADD;     // Also the address add for loads and stores
        imm      = imm_i;
        use_imm  = 1'b0;
        reg_we   = 1'b0;
        is_load  = 1'b0;
        is_store = 1'b0;

        case (inst.opcode)
            OPC_OP: begin
                alu_op = funct_to_op(inst.funct3, inst.funct7[5], 1'b1);
                reg_we = rd_nz;
            end
            OPC_OP_IMM: begin
                alu_op  = funct_to_op(inst.funct3, inst.funct7[5], 1'b0);
                use_imm = 1'b1;
                reg_we  = rd_nz;
            end
            OPC_LOAD: begin
                use_imm = 1'b1;
                reg_we  = rd_nz;
                is_load = 1'b1;
            end
            OPC_STORE: begin
                imm      = imm_s;
                use_imm  = 1'b1;
                is_store = 1'b1;
            end
            default: ;          // Unsupported opcode retires as a no-op
        endcase
    end

endmodule

//--- rv_alu.sv
module rv_alu (
    input  rv_pkg::alu_op_e op,
    input  rv_pkg::word_t   a,
    input  rv_pkg::word_t   b,
    output rv_pkg::word_t   y
);

    import rv_pkg::*;

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0];                    // Only low 5 bits shift
    assign lt_signed   = ($signed(a) < $signed(b));
    assign lt_unsigned = (a < b);

    always_comb begin
        case (op)
            ALU_ADD:  y = a + b;
            ALU_SUB:  y = a - b;
            ALU_SLL:  y = a << shamt;
            ALU_SLT:  y = word_t'(lt_signed);
            ALU_SLTU: y = word_t'(lt_unsigned);
            ALU_XOR:  y = a ^ b;
            ALU_SRL:  y = a >> shamt;
            ALU_SRA:  y = word_t'($signed(a) >>> shamt);  // Fills with sign bit
            ALU_OR:   y = a | b;
            ALU_AND:  y = a & b;
            default:  y = '0;
        endcase
    end

endmodule

//--- rv_single_cpu.sv
`include "rv_defs.svh"

module rv_single_cpu (
    input  logic                   CLK,
    input  logic                   RST,
    input  logic                   run,
    input  logic                   imem_we,
    input  logic [`RV_IMEM_AW-1:0] imem_addr,
    input  rv_pkg::inst_t          imem_wdata,
    output rv_pkg::word_t          pc,
    output logic                   wb_we,
    output rv_pkg::reg_idx_t       wb_rd,
    output rv_pkg::word_t          wb_data,
    output logic                   st_we,
    output logic [`RV_DMEM_AW-1:0] st_addr,
    output rv_pkg::word_t          st_data
);

    import rv_pkg::*;

    logic [`RV_IMEM_AW-1:0] pc_idx;     // Word index of the fetch address
    inst_t                  inst;

    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    alu_op_e  alu_op;
    word_t    imm;
    logic     use_imm;
    logic     reg_we;
    logic     is_load;
    logic     is_store;

    word_t rd1;
    word_t rd2;
    word_t alu_b;
    word_t result;
    word_t dmem_rdata;

    logic [`RV_DMEM_AW-1:0] dmem_addr;

    // Fetch counter, wraps at the end of instruction memory
    always_ff @(posedge CLK) begin
        if (RST) begin
            pc_idx <= '0;
        end else if (run) begin
            pc_idx <= pc_idx + 1'b1;
        end
    end

    assign pc = word_t'({pc_idx, 2'b00});   // Byte address

    rv_word_ram #(
        .AW        (`RV_IMEM_AW),
        .payload_t (inst_t)
    ) u_imem (
        .CLK   (CLK),
        .we    (imem_we & ~run),        // Loading only while halted
        .waddr (imem_addr),
        .wdata (imem_wdata),
        .raddr (pc_idx),
        .rdata (inst)
    );

    rv_decoder u_decoder (
        .inst     (inst),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .alu_op   (alu_op),
        .imm      (imm),
        .use_imm  (use_imm),
        .reg_we   (reg_we),
        .is_load  (is_load),
        .is_store (is_store)
    );

    rv_regfile u_regfile (
        .CLK    (CLK),
        .RST    (RST),
        .rs1    (rs1),
        .rs2    (rs2),
        .we     (wb_we),
        .rd     (rd),
        .wdata  (wb_data),
        .rdata1 (rd1),
        .rdata2 (rd2)
    );

    assign alu_b = use_imm ? imm : rd2;     // Operand select

    rv_alu u_alu (
        .op (alu_op),
        .a  (rd1),
        .b  (alu_b),
        .y  (result)
    );

    // Word address from the byte address, upper bits ignored
    assign dmem_addr = result[`RV_DMEM_AW+1:2];

    rv_word_ram #(
        .AW        (`RV_DMEM_AW),
        .payload_t (word_t)
    ) u_dmem (
        .CLK   (CLK),
        .we    (st_we),
        .waddr (dmem_addr),
        .wdata (rd2),
        .raddr (dmem_addr),
        .rdata (dmem_rdata)
    );

    // Writeback select
    assign wb_data = is_load ? dmem_rdata : result;
    assign wb_rd   = rd;
    assign wb_we   = run & reg_we;          // Halting suppresses every write

    assign st_we   = run & is_store;
    assign st_addr = dmem_addr;
    assign st_data = rd2;

endmodule

//--- tb_rv_single_cpu.sv
`include "rv_defs.svh"

module tb_rv_single_cpu;

    import rv_pkg::*;

    typedef logic [`RV_IMEM_AW-1:0] iaddr_t;
    typedef logic [`RV_DMEM_AW-1:0] daddr_t;

    localparam int    IMEM_WORDS = 2 ** `RV_IMEM_AW;
    localparam int    DMEM_WORDS = 2 ** `RV_DMEM_AW;
    localparam int    RUN_LIMIT  = 400;     // Cycles allowed for one program pass
    localparam word_t PC_MASK    = word_t'((1 << (`RV_IMEM_AW + 2)) - 1);

    logic     CLK;
    logic     RST;
    logic     run;
    logic     imem_we;
    iaddr_t   imem_addr;
    inst_t    imem_wdata;
    word_t    pc;
    logic     wb_we;
    reg_idx_t wb_rd;
    word_t    wb_data;
    logic     st_we;
    daddr_t   st_addr;
    word_t    st_data;

    inst_t prog [IMEM_WORDS];
    word_t m_regs [32];             // Reference register file with x0 never written
    word_t m_dmem [DMEM_WORDS];
    word_t m_pc;
    int    stored_q [$];            // Word slots written by earlier stores

    rv_single_cpu u_rv_single_cpu (
        .CLK        (CLK),
        .RST        (RST),
        .run        (run),
        .imem_we    (imem_we),
        .imem_addr  (imem_addr),
        .imem_wdata (imem_wdata),
        .pc         (pc),
        .wb_we      (wb_we),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .st_we      (st_we),
        .st_addr    (st_addr),
        .st_data    (st_data)
    );

    initial CLK = 1'b0;
    always #10 CLK = ~CLK;

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("ERROR t=%0t %s expected %08h actual %08h", $time, name, exp, act);
            $display("test failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic check_idx(input string name, input reg_idx_t exp, input reg_idx_t act);
        if (act !== exp) begin
            $display("ERROR t=%0t %s expected x%0d actual x%0d", $time, name, exp, act);
            $display("test failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR t=%0t %s expected %b actual %b", $time, name, exp, act);
            $display("test failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    function automatic inst_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] f3,
                                    input reg_idx_t rd);
        inst_t v;
        v = {f7, rs2, rs1, f3, rd, OPC_OP};
        return v;
    endfunction

    function automatic inst_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                    input logic [2:0] f3, input reg_idx_t rd,
                                    input logic [6:0] opc);
        inst_t v;
        v = {imm, rs1, f3, rd, opc};
        return v;
    endfunction

    function automatic inst_t enc_s(input logic [11:0] imm, input reg_idx_t rs2,
                                    input reg_idx_t rs1);
        inst_t v;
        v = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};   // sw
        return v;
    endfunction

    // x0 as destination one time in eight
    function automatic reg_idx_t pick_rd();
        if ($urandom_range(0, 7) == 0) begin
            return '0;
        end
        return reg_idx_t'($urandom_range(1, 31));
    endfunction

    function automatic reg_idx_t pick_rs();
        return reg_idx_t'($urandom_range(0, 31));
    endfunction

    // RV32I integer result for funct3 and bit 30
    function automatic word_t alu_model(input logic [2:0] f3, input logic alt,
                                        input logic is_reg, input word_t a, input word_t b);
        word_t y;
        case (f3)
            3'd0:    y = (alt && is_reg) ? a - b : a + b;
            3'd1:    y = a << b[4:0];
            3'd2:    y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    y = (a < b) ? 32'd1 : 32'd0;
            3'd4:    y = a ^ b;
            3'd5:    y = alt ? word_t'($signed(a) >>> b[4:0]) : (a >> b[4:0]);
            3'd6:    y = a | b;
            default: y = a & b;
        endcase
        return y;
    endfunction

    task automatic build_program();
        int          kind;
        int          slot;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        reg_idx_t    rd_v;
        reg_idx_t    rs1_v;
        reg_idx_t    rs2_v;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            kind  = $urandom_range(0, 9);
            f3    = 3'($urandom_range(0, 7));
            alt   = 1'($urandom_range(0, 1));
            rd_v  = pick_rd();
            rs1_v = pick_rs();
            rs2_v = pick_rs();
            imm   = 12'($urandom);
            if (kind < 4) begin
                prog[i] = enc_r((alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
                                rs2_v, rs1_v, f3, rd_v);
            end else if (kind < 7) begin
                if (f3 == 3'd1) begin
                    imm = {7'h00, imm[4:0]};                        // slli
                end else if (f3 == 3'd5) begin
                    imm = {(alt ? 7'h20 : 7'h00), imm[4:0]};        // srli or srai
                end
                prog[i] = enc_i(imm, rs1_v, f3, rd_v, OPC_OP_IMM);
            end else if (kind == 7) begin
                slot = $urandom_range(0, DMEM_WORDS - 1);
                stored_q.push_back(slot);
                prog[i] = enc_s(12'(slot * 4), rs2_v, '0);
            end else if (stored_q.size() > 0) begin
                slot = stored_q[$urandom_range(0, stored_q.size() - 1)];
                prog[i] = enc_i(12'(slot * 4), '0, 3'b010, rd_v, OPC_LOAD);
            end else begin
                prog[i] = enc_i(imm, rs1_v, 3'b000, rd_v, OPC_OP_IMM);  // addi stand-in
            end
        end
    endtask

    // Check the ports for the instruction at m_pc and apply the coming edge
    task automatic model_step();
        logic [31:0] ins;
        logic [2:0]  f3;
        reg_idx_t    rd;
        word_t       a;
        word_t       b;
        word_t       imm_i;
        word_t       imm_s;
        word_t       res;
        daddr_t      daddr;
        logic        exp_wb;
        logic        exp_st;
        ins    = prog[m_pc[`RV_IMEM_AW+1:2]];
        f3     = ins[14:12];
        rd     = ins[11:7];
        a      = m_regs[ins[19:15]];
        b      = m_regs[ins[24:20]];
        imm_i  = {{20{ins[31]}}, ins[31:20]};
        imm_s  = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        res    = '0;
        daddr  = '0;
        exp_wb = 1'b0;
        exp_st = 1'b0;
        case (ins[6:0])
            OPC_OP: begin
                res    = alu_model(f3, ins[30], 1'b1, a, b);
                exp_wb = (rd != '0);
            end
            OPC_OP_IMM: begin
                res    = alu_model(f3, ins[30], 1'b0, a, imm_i);
                exp_wb = (rd != '0);
            end
            OPC_LOAD: begin
                daddr  = daddr_t'((a + imm_i) >> 2);
                res    = m_dmem[daddr];
                exp_wb = (rd != '0);
            end
            OPC_STORE: begin
                daddr  = daddr_t'((a + imm_s) >> 2);
                exp_st = 1'b1;
            end
            default: ;
        endcase
        if (!run) begin
            exp_wb = 1'b0;      // Halted core commits nothing
            exp_st = 1'b0;
        end

        check_word("pc", m_pc, pc);
        check_bit("wb_we", exp_wb, wb_we);
        check_bit("st_we", exp_st, st_we);
        if (exp_wb) begin
            check_idx("wb_rd", rd, wb_rd);
            check_word("wb_data", res, wb_data);
            m_regs[rd] = res;
        end
        if (exp_st) begin
            check_word("st_addr", word_t'(daddr), word_t'(st_addr));
            check_word("st_data", b, st_data);
            m_dmem[daddr] = b;
        end
        if (run) begin
            m_pc = (m_pc + 32'd4) & PC_MASK;
        end
    endtask

    // Drive just after the rising edge and check mid-cycle
    task automatic drive_cycle(input logic run_val, input logic we_val,
                               input iaddr_t addr_val, input inst_t data_val);
        @(posedge CLK);
        #1;
        run        = run_val;
        imem_we    = we_val;
        imem_addr  = addr_val;
        imem_wdata = data_val;
        @(negedge CLK);
        model_step();
    endtask

    initial begin
        int executed;
        int cycles;
        int hold;
        int next_freeze;
        int freeze_at [2];

        void'($urandom(32'h8cacec8c));
        RST        = 1'b1;
        run        = 1'b0;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = '0;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            m_dmem[i] = '0;
        end
        m_pc = '0;

        build_program();
        repeat (10) @(posedge CLK);
        #1;
        RST = 1'b0;

        // Load the program while halted
        for (int i = 0; i < IMEM_WORDS; i++) begin
            drive_cycle(1'b0, 1'b1, iaddr_t'(i), prog[i]);
        end

        freeze_at[0] = $urandom_range(20, 120);
        freeze_at[1] = $urandom_range(130, 240);
        next_freeze  = 0;
        executed     = 0;
        cycles       = 0;
        hold         = 0;
        while (executed < IMEM_WORDS) begin
            if (cycles >= RUN_LIMIT) begin
                $display("Timed out: program pass incomplete after %0d cycles", cycles);
                $display("test failed");
                $fatal(1, "Run loop timeout");
            end
            if (hold == 0 && next_freeze < 2 && executed == freeze_at[next_freeze]) begin
                hold = $urandom_range(2, 5);    // Short halt mid-program
                next_freeze++;
            end
            if (hold > 0) begin
                hold--;
                drive_cycle(1'b0, 1'b0, '0, '0);
            end else begin
                drive_cycle(1'b1, 1'b0, '0, '0);
                executed++;
            end
            cycles++;
        end

        // pc must read 0 again after one full pass
        drive_cycle(1'b0, 1'b0, '0, '0);

        $display("test passed");
        $finish;
    end

endmodule

//--- rv_single_cpu.f
+incdir+.
rv_pkg.sv
rv_word_ram.sv
rv_regfile.sv
rv_decoder.sv
rv_alu.sv
rv_single_cpu.sv
tb_rv_single_cpu.sv

//--- Makefile
TOP = tb_rv_single_cpu

SRCS = rv_defs.svh rv_pkg.sv rv_word_ram.sv rv_regfile.sv rv_decoder.sv \
       rv_alu.sv rv_single_cpu.sv tb_rv_single_cpu.sv

.PHONY: all compile run clean

all: run

compile: obj_dir/$(TOP)

obj_dir/$(TOP): rv_single_cpu.f $(SRCS)
	verilator --binary -f rv_single_cpu.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

# Exit status of the binary is the pass or fail result
run: compile
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
